// File: src/lv8_config.svh
`ifndef LV8_CONFIG_SVH
`define LV8_CONFIG_SVH

// Datapath and address width
`define LV8_XLEN 64

`define LV8_INSN_W 32    // Instruction word
`define LV8_OPCODE_W 11  // Bits 31:21 of the instruction

// Register file shape
`define LV8_REG_AW 5
`define LV8_NUM_REGS 32
`define LV8_ZERO_REG 31  // Hardwired to zero

// Bytes per instruction
`define LV8_PC_STEP 4

// Data memory is 64-bit word addressed
`define LV8_DMEM_WORD_SHIFT 3

`endif

// File: src/lv8_pkg.sv
`include "lv8_config.svh"

package lv8_pkg;

  // Opcode field values of the supported LEGv8 subset
  typedef enum logic [`LV8_OPCODE_W-1:0] {
    OP_STUR = 11'b11111000000,
    OP_LDUR = 11'b11111000010,
    OP_ADD  = 11'b10001011000,
    OP_SUB  = 11'b11001011000,
    OP_AND  = 11'b10001010000,
    OP_ORR  = 11'b10101010000
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_ORR
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;  // Immediate as second ALU operand
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_read;
    logic mem_write;
  } mem_ctrl_t;

  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;  // Load data instead of ALU result
  } wb_ctrl_t;

  typedef struct packed {
    logic [`LV8_XLEN-1:0] addr;
    logic [`LV8_XLEN-1:0] wdata;
    logic                 read;
    logic                 write;
  } dmem_req_t;

  typedef struct packed {
    logic                   en;
    logic [`LV8_REG_AW-1:0] rd;
    logic [`LV8_XLEN-1:0]   data;
  } wb_t;

  typedef struct packed {
    ex_ctrl_t               ex_ctrl;
    mem_ctrl_t              mem_ctrl;
    wb_ctrl_t               wb_ctrl;
    logic [`LV8_XLEN-1:0]   rs1_val;
    logic [`LV8_XLEN-1:0]   rs2_val;
    logic [`LV8_XLEN-1:0]   imm;
    logic [`LV8_REG_AW-1:0] rd;
    logic [`LV8_REG_AW-1:0] rs1;
    logic [`LV8_REG_AW-1:0] rs2;  // Rm, or Rt for stores
  } id_ex_t;

endpackage

// File: src/lv8_fetch.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_fetch (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic [`LV8_INSN_W-1:0] imem_data,
  output logic [`LV8_XLEN-1:0]   pc,
  output logic [`LV8_INSN_W-1:0] if_insn
);

  localparam logic [`LV8_XLEN-1:0] PC_STEP = `LV8_PC_STEP;

  // Program counter, frozen during a load-use stall
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + PC_STEP;  // No branches, straight-line fetch
    end
  end

  // IF/ID instruction register
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      if_insn <= '0;             // All-zero word decodes as NOP
    end else if (!stall) begin
      if_insn <= imem_data;
    end
  end

endmodule

// File: src/lv8_regfile.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_regfile (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic [`LV8_REG_AW-1:0] rd_idx_a,
  input  logic [`LV8_REG_AW-1:0] rd_idx_b,
  output logic [`LV8_XLEN-1:0]   rd_data_a,
  output logic [`LV8_XLEN-1:0]   rd_data_b,
  input  lv8_pkg::wb_t           wb
);

  localparam logic [`LV8_REG_AW-1:0] ZERO_REG = `LV8_ZERO_REG;

  logic [`LV8_XLEN-1:0] regs [`LV8_NUM_REGS-1];  // x0..x30 only

  function automatic logic [`LV8_XLEN-1:0] read_port(input logic [`LV8_REG_AW-1:0] idx);
    if (idx == ZERO_REG) return '0;
    if (wb.en && (wb.rd == idx)) return wb.data;  // Write-through
    return regs[idx];
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_idx_a);
    rd_data_b = read_port(rd_idx_b);
  end

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      for (int i = 0; i < `LV8_NUM_REGS - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != ZERO_REG)) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

// File: src/lv8_decode.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_decode (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic [`LV8_INSN_W-1:0] if_insn,
  output logic [`LV8_REG_AW-1:0] rd_idx_a,
  output logic [`LV8_REG_AW-1:0] rd_idx_b,
  input  logic [`LV8_XLEN-1:0]   rd_data_a,
  input  logic [`LV8_XLEN-1:0]   rd_data_b,
  output logic                   stall,
  output lv8_pkg::id_ex_t        id_ex
);

  localparam logic [`LV8_REG_AW-1:0] ZERO_REG = `LV8_ZERO_REG;

  logic [`LV8_OPCODE_W-1:0] opcode;
  logic [`LV8_REG_AW-1:0]   dest;
  logic [`LV8_XLEN-1:0]     imm;
  lv8_pkg::ex_ctrl_t        ex_ctrl;
  lv8_pkg::mem_ctrl_t       mem_ctrl;
  lv8_pkg::wb_ctrl_t        wb_ctrl;
  lv8_pkg::id_ex_t          id_ex_next;

  assign opcode   = if_insn[31:21];
  assign dest     = if_insn[4:0];
  assign rd_idx_a = if_insn[9:5];                                // Rn
  assign rd_idx_b = if_insn[28] ? if_insn[4:0] : if_insn[20:16]; // Rt for D-type, else Rm

  // Sign-extended 9-bit D-type offset
  assign imm = {{(`LV8_XLEN - 9){if_insn[20]}}, if_insn[20:12]};

  always_comb begin
    ex_ctrl  = '0;
    mem_ctrl = '0;
    wb_ctrl  = '0;
    case (opcode)
      lv8_pkg::OP_LDUR: begin
        ex_ctrl.alu_src    = 1'b1;       // Address is Rn + offset
        mem_ctrl.mem_read  = 1'b1;
        wb_ctrl.reg_write  = 1'b1;
        wb_ctrl.mem_to_reg = 1'b1;
      end
      lv8_pkg::OP_STUR: begin
        ex_ctrl.alu_src    = 1'b1;
        mem_ctrl.mem_write = 1'b1;
      end
      lv8_pkg::OP_ADD: begin
        wb_ctrl.reg_write  = 1'b1;
      end
      lv8_pkg::OP_SUB: begin
        ex_ctrl.alu_op     = lv8_pkg::ALU_SUB;
        wb_ctrl.reg_write  = 1'b1;
      end
      lv8_pkg::OP_AND: begin
        ex_ctrl.alu_op     = lv8_pkg::ALU_AND;
        wb_ctrl.reg_write  = 1'b1;
      end
      lv8_pkg::OP_ORR: begin
        ex_ctrl.alu_op     = lv8_pkg::ALU_ORR;
        wb_ctrl.reg_write  = 1'b1;
      end
      default: ;                         // Anything else runs as a NOP
    endcase
    if (dest == ZERO_REG) begin
      wb_ctrl.reg_write = 1'b0;          // Writes to x31 are dropped here
    end
  end

  always_comb begin
    id_ex_next          = '0;
    id_ex_next.ex_ctrl  = ex_ctrl;
    id_ex_next.mem_ctrl = mem_ctrl;
    id_ex_next.wb_ctrl  = wb_ctrl;
    id_ex_next.rs1_val  = rd_data_a;
    id_ex_next.rs2_val  = rd_data_b;
    id_ex_next.imm      = imm;
    id_ex_next.rd       = dest;
    id_ex_next.rs1      = rd_idx_a;
    id_ex_next.rs2      = rd_idx_b;
  end

  // Load in EX feeding the instruction now in decode
  assign stall = id_ex.mem_ctrl.mem_read &&
                 ((id_ex.rd == rd_idx_a) || (id_ex.rd == rd_idx_b));

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (stall) begin
      id_ex <= '0;                       // Bubble
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

// File: src/lv8_execute.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_execute (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  lv8_pkg::id_ex_t        id_ex,
  input  lv8_pkg::wb_t           wb,
  output lv8_pkg::dmem_req_t     dmem_req,
  output logic [`LV8_REG_AW-1:0] ex_rd,
  output lv8_pkg::wb_ctrl_t      ex_wb_ctrl
);

  logic [`LV8_XLEN-1:0] op_a;
  logic [`LV8_XLEN-1:0] fwd_b;
  logic [`LV8_XLEN-1:0] op_b;
  logic [`LV8_XLEN-1:0] alu_result;

  // Newest producer wins, EX/MEM ahead of write-back
  function automatic logic [`LV8_XLEN-1:0] fwd_sel(
    input logic [`LV8_REG_AW-1:0] src,
    input logic [`LV8_XLEN-1:0]   id_val
  );
    if (ex_wb_ctrl.reg_write && !ex_wb_ctrl.mem_to_reg && (ex_rd == src)) begin
      return dmem_req.addr;              // ALU result still in EX/MEM
    end
    if (wb.en && (wb.rd == src)) begin
      return wb.data;
    end
    return id_val;
  endfunction

  always_comb begin
    op_a  = fwd_sel(id_ex.rs1, id_ex.rs1_val);
    fwd_b = fwd_sel(id_ex.rs2, id_ex.rs2_val);
    op_b  = id_ex.ex_ctrl.alu_src ? id_ex.imm : fwd_b;
  end

  always_comb begin
    case (id_ex.ex_ctrl.alu_op)
      lv8_pkg::ALU_ADD: alu_result = op_a + op_b;
      lv8_pkg::ALU_SUB: alu_result = op_a - op_b;
      lv8_pkg::ALU_AND: alu_result = op_a & op_b;
      lv8_pkg::ALU_ORR: alu_result = op_a | op_b;
    endcase
  end

  // EX/MEM register, its outputs form the data-memory request
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      dmem_req.read  <= 1'b0;
      dmem_req.write <= 1'b0;
      ex_wb_ctrl     <= '0;
    end else begin
      dmem_req.read  <= id_ex.mem_ctrl.mem_read;
      dmem_req.write <= id_ex.mem_ctrl.mem_write;
      ex_wb_ctrl     <= id_ex.wb_ctrl;
    end
    dmem_req.addr  <= alu_result;
    dmem_req.wdata <= fwd_b;             // Store data after forwarding
    ex_rd          <= id_ex.rd;
  end

endmodule

// File: src/lv8_mem_wb.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_mem_wb (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  lv8_pkg::dmem_req_t     dmem_req,
  input  logic [`LV8_XLEN-1:0]   dmem_rdata,
  input  logic [`LV8_REG_AW-1:0] ex_rd,
  input  lv8_pkg::wb_ctrl_t      ex_wb_ctrl,
  output lv8_pkg::wb_t           wb
);

  lv8_pkg::wb_ctrl_t      wb_ctrl_q;
  logic [`LV8_XLEN-1:0]   alu_q;
  logic [`LV8_XLEN-1:0]   load_q;
  logic [`LV8_REG_AW-1:0] rd_q;

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      wb_ctrl_q <= '0;
    end else begin
      wb_ctrl_q <= ex_wb_ctrl;
    end
    alu_q  <= dmem_req.addr;  // Address doubles as the ALU result
    load_q <= dmem_rdata;
    rd_q   <= ex_rd;
  end

  always_comb begin
    wb.en   = wb_ctrl_q.reg_write;
    wb.rd   = rd_q;
    wb.data = wb_ctrl_q.mem_to_reg ? load_q : alu_q;
  end

endmodule

// File: src/lv8_core.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_core (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  output logic [`LV8_XLEN-1:0]   imem_addr,
  input  logic [`LV8_INSN_W-1:0] imem_data,
  output lv8_pkg::dmem_req_t     dmem_req,
  input  logic [`LV8_XLEN-1:0]   dmem_rdata,
  output lv8_pkg::wb_t           wb
);

  logic [`LV8_INSN_W-1:0] if_insn;
  logic                   stall;
  logic [`LV8_REG_AW-1:0] rd_idx_a;
  logic [`LV8_REG_AW-1:0] rd_idx_b;
  logic [`LV8_XLEN-1:0]   rd_data_a;
  logic [`LV8_XLEN-1:0]   rd_data_b;
  lv8_pkg::id_ex_t        id_ex;
  logic [`LV8_REG_AW-1:0] ex_rd;
  lv8_pkg::wb_ctrl_t      ex_wb_ctrl;

  lv8_fetch fetch_i (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .stall     (stall),
    .imem_data (imem_data),
    .pc        (imem_addr),
    .if_insn   (if_insn)
  );

  lv8_regfile regfile_i (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (wb)
  );

  lv8_decode decode_i (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .if_insn   (if_insn),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .stall     (stall),
    .id_ex     (id_ex)
  );

  lv8_execute execute_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .id_ex      (id_ex),
    .wb         (wb),         // Write-back forwarding path
    .dmem_req   (dmem_req),
    .ex_rd      (ex_rd),
    .ex_wb_ctrl (ex_wb_ctrl)
  );

  lv8_mem_wb mem_wb_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .ex_rd      (ex_rd),
    .ex_wb_ctrl (ex_wb_ctrl),
    .wb         (wb)
  );

endmodule

// File: sim/lv8_clock_gen.sv
`timescale 1ns/10ps

module lv8_clock_gen (
  output logic CLOCK,
  output logic rst_n,
  input  logic rst_req
);

  int rst_cnt = 0;

  initial CLOCK = 1'b0;
  always #10 CLOCK = ~CLOCK;  // 20 ns period

  // Reset held low for 10 cycles, restarted by rst_req
  always @(negedge CLOCK) begin
    if (rst_req) begin
      rst_cnt <= 0;
    end else if (rst_cnt < 10) begin
      rst_cnt <= rst_cnt + 1;
    end
  end

  assign rst_n = (rst_cnt >= 10);

endmodule

// File: sim/lv8_core_sva.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_core_sva (
  input logic               CLOCK,
  input logic               rst_n,
  input lv8_pkg::dmem_req_t dmem_req,
  input lv8_pkg::wb_t       wb
);

  localparam logic [`LV8_REG_AW-1:0] ZERO_REG = `LV8_ZERO_REG;

  // One memory access per cycle
  no_read_and_write: assert property (@(posedge CLOCK) disable iff (!rst_n)
    !(dmem_req.read && dmem_req.write))
    else $error("Data memory read and write strobes high together");

  no_zero_reg_write: assert property (@(posedge CLOCK) disable iff (!rst_n)
    wb.en |-> (wb.rd != ZERO_REG))
    else $error("Write-back targets the zero register");

  // Strobes cleared by the reset edge
  strobes_low_after_reset: assert property (@(posedge CLOCK)
    !rst_n |=> (!wb.en && !dmem_req.read && !dmem_req.write))
    else $error("Strobe high in the cycle after reset");

endmodule

bind lv8_core lv8_core_sva core_sva_i (
  .CLOCK    (CLOCK),
  .rst_n    (rst_n),
  .dmem_req (dmem_req),
  .wb       (wb)
);

// File: sim/lv8_tb.sv
`timescale 1ns/10ps
`include "lv8_config.svh"

module lv8_tb;

  localparam int IMEM_WORDS = 256;

  logic                   CLOCK;
  logic                   rst_n;
  logic                   rst_req = 1'b0;
  logic [`LV8_XLEN-1:0]   imem_addr;
  logic [`LV8_INSN_W-1:0] imem_data = '0;
  lv8_pkg::dmem_req_t     dmem_req;
  logic [`LV8_XLEN-1:0]   dmem_rdata = '0;
  lv8_pkg::wb_t           wb;

  logic [`LV8_INSN_W-1:0] imem [IMEM_WORDS];
  logic [`LV8_XLEN-1:0]   dmem [128];
  logic [`LV8_INSN_W-1:0] prog [$];
  logic [68:0]            exp_wb [$];  // {rd, data}
  logic [127:0]           exp_st [$];  // {addr, data}
  logic [31:0]            rng = 32'h5fa4;
  logic                   active = 1'b0;
  string                  cur_name = "";
  int                     test_errs = 0;
  int                     bad_tests = 0;
  int                     good_tests = 0;

  lv8_clock_gen clock_gen_i (.CLOCK(CLOCK), .rst_n(rst_n), .rst_req(rst_req));

  lv8_core lv8_core_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

  function automatic int word_idx(input logic [`LV8_XLEN-1:0] addr);
    return int'((addr >> `LV8_DMEM_WORD_SHIFT) & 64'd127);
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input lv8_pkg::opcode_e op, input logic [4:0] rd,
                                        input logic [4:0] rn, input logic [4:0] rm);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] enc_d(input lv8_pkg::opcode_e op, input logic [4:0] rt,
                                        input logic [4:0] rn, input logic [8:0] off);
    return {op, off, 2'b00, rn, rt};
  endfunction

  function automatic logic [4:0] pick_reg(input logic [31:0] r);
    return (r % 9 == 8) ? 5'd31 : 5'(r % 9);  // x0..x7 or x31
  endfunction

  // Architectural execution of prog in order
  function automatic void ref_model();
    logic [63:0] r [32];
    logic [63:0] m [128];
    logic [10:0] op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] res;
    logic        wr;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 128; i++) m[i] = 64'(i * 5);
    foreach (prog[k]) begin
      op  = prog[k][31:21];
      a   = r[prog[k][9:5]];
      b   = r[prog[k][20:16]];
      imm = {{55{prog[k][20]}}, prog[k][20:12]};
      wr  = 1'b1;
      res = '0;
      case (op)
        lv8_pkg::OP_ADD:  res = a + b;
        lv8_pkg::OP_SUB:  res = a - b;
        lv8_pkg::OP_AND:  res = a & b;
        lv8_pkg::OP_ORR:  res = a | b;
        lv8_pkg::OP_LDUR: res = m[word_idx(a + imm)];
        lv8_pkg::OP_STUR: begin
          wr = 1'b0;
          m[word_idx(a + imm)] = r[prog[k][4:0]];
          exp_st.push_back({a + imm, r[prog[k][4:0]]});
        end
        default: wr = 1'b0;
      endcase
      if (wr && prog[k][4:0] != 5'd31) begin  // x31 stays zero
        r[prog[k][4:0]] = res;
        exp_wb.push_back({prog[k][4:0], res});
      end
    end
  endfunction

  // Instruction and data memory models
  always @(negedge CLOCK) begin
    if (!rst_n) begin
      for (int i = 0; i < 128; i++) dmem[i] = 64'(i * 5);
    end else if (dmem_req.write) begin
      dmem[word_idx(dmem_req.addr)] = dmem_req.wdata;
    end
    imem_data  <= (imem_addr[63:2] < IMEM_WORDS) ? imem[imem_addr[9:2]] : '0;
    dmem_rdata <= dmem_req.read ? dmem[word_idx(dmem_req.addr)] : '0;
  end

  // Compare write-back and store events in order
  always @(negedge CLOCK) begin
    logic [68:0]  ew;
    logic [127:0] es;
    if (active && rst_n) begin
      if (wb.en) begin
        if (exp_wb.size() == 0) begin
          $display("Error in %s: unexpected write-back to x%0d", cur_name, wb.rd);
          test_errs++;
        end else begin
          ew = exp_wb.pop_front();
          if ({wb.rd, wb.data} !== ew) begin
            $display("Fail %s: expected x%0d=%h, actual x%0d=%h", cur_name,
                     ew[68:64], ew[63:0], wb.rd, wb.data);
            test_errs++;
          end
        end
      end
      if (dmem_req.write) begin
        if (exp_st.size() == 0) begin
          $display("Error in %s: unexpected store to %h", cur_name, dmem_req.addr);
          test_errs++;
        end else begin
          es = exp_st.pop_front();
          if ({dmem_req.addr, dmem_req.wdata} !== es) begin
            $display("Fail %s: expected [%h]=%h, actual [%h]=%h", cur_name,
                     es[127:64], es[63:0], dmem_req.addr, dmem_req.wdata);
            test_errs++;
          end
        end
      end
    end
  end

  task automatic run_test(input string name, input bit startup);
    int          cyc;
    int          budget;
    logic [63:0] last_pc;
    budget = 60 + 4 * prog.size();
    @(posedge CLOCK);
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = (i < prog.size()) ? prog[i] : '0;
    exp_wb.delete();
    exp_st.delete();
    ref_model();
    cur_name  = name;
    test_errs = 0;
    active    = 1'b1;
    @(negedge CLOCK);
    rst_req <= 1'b1;
    @(negedge CLOCK);
    rst_req <= 1'b0;
    cyc     = 0;
    last_pc = '1;
    do begin
      @(negedge CLOCK);
      if (!rst_n) last_pc = imem_addr;  // Fetch address just before release
      cyc++;
    end while (!rst_n && cyc < budget);
    if (!rst_n) begin
      $display("Error in %s: reset never released", name);
      test_errs++;
    end
    if (startup) begin
      if (last_pc !== '0) begin
        $display("Fail %s: expected pc=%h, actual pc=%h", name, 64'd0, last_pc);
        test_errs++;
      end
      for (int k = 0; k < 3; k++) begin  // Cycles before first write-back
        if (k > 0) @(negedge CLOCK);
        if (wb.en || dmem_req.read || dmem_req.write) begin
          $display("Fail %s: expected strobes=000, actual strobes=%b%b%b", name,
                   wb.en, dmem_req.read, dmem_req.write);
          test_errs++;
        end
      end
    end
    cyc = 0;
    while ((exp_wb.size() != 0 || exp_st.size() != 0) && cyc < budget) begin
      @(posedge CLOCK);
      cyc++;
    end
    if (exp_wb.size() != 0 || exp_st.size() != 0) begin
      $display("Error in %s: timed out with %0d write-backs and %0d stores missing",
               name, exp_wb.size(), exp_st.size());
      test_errs++;
    end
    repeat (8) @(posedge CLOCK);  // Catch late duplicates
    active = 1'b0;
    if (test_errs == 0) begin
      $display("Test %s: ok", name);
      good_tests++;
    end else begin
      $display("Test %s: %0d errors", name, test_errs);
      bad_tests++;
    end
  endtask

  initial begin
    prog = '{enc_r(lv8_pkg::OP_ADD, 1, 31, 31), enc_r(lv8_pkg::OP_ADD, 2, 1, 31)};
    run_test("startup", 1'b1);

    prog = '{enc_d(lv8_pkg::OP_LDUR, 1, 31, 8), enc_d(lv8_pkg::OP_LDUR, 2, 31, 16),
             enc_r(lv8_pkg::OP_ADD, 3, 1, 2), enc_r(lv8_pkg::OP_SUB, 4, 3, 1),
             enc_r(lv8_pkg::OP_AND, 5, 4, 3), enc_r(lv8_pkg::OP_ORR, 3, 5, 4),
             enc_r(lv8_pkg::OP_ADD, 3, 3, 1), enc_r(lv8_pkg::OP_SUB, 6, 3, 2)};
    run_test("alu_chain", 1'b0);

    prog = '{enc_d(lv8_pkg::OP_LDUR, 1, 31, 24), enc_r(lv8_pkg::OP_ADD, 2, 1, 1),
             enc_d(lv8_pkg::OP_LDUR, 3, 2, 0), enc_r(lv8_pkg::OP_SUB, 4, 3, 1),
             enc_d(lv8_pkg::OP_LDUR, 5, 4, 8), enc_r(lv8_pkg::OP_ORR, 6, 5, 3)};
    run_test("load_use", 1'b0);

    prog = '{enc_d(lv8_pkg::OP_LDUR, 1, 31, 40), enc_r(lv8_pkg::OP_ADD, 2, 1, 1),
             enc_d(lv8_pkg::OP_STUR, 2, 31, 0), enc_r(lv8_pkg::OP_SUB, 3, 2, 1),
             enc_d(lv8_pkg::OP_STUR, 3, 1, 8), enc_d(lv8_pkg::OP_LDUR, 4, 31, 0),
             enc_d(lv8_pkg::OP_STUR, 4, 31, 16), enc_d(lv8_pkg::OP_LDUR, 5, 31, 16)};
    run_test("store_fwd", 1'b0);

    prog = '{enc_d(lv8_pkg::OP_LDUR, 1, 31, 8), enc_r(lv8_pkg::OP_ADD, 31, 1, 1),
             enc_r(lv8_pkg::OP_SUB, 2, 31, 1), enc_r(lv8_pkg::OP_ORR, 31, 2, 2),
             enc_r(lv8_pkg::OP_AND, 3, 2, 31), enc_r(lv8_pkg::OP_ADD, 4, 31, 1),
             enc_d(lv8_pkg::OP_LDUR, 31, 31, 8), enc_r(lv8_pkg::OP_ADD, 5, 31, 1)};
    run_test("zero_reg", 1'b0);

    prog.delete();
    for (int i = 0; i < 200; i++) begin
      logic [4:0] rd;
      logic [4:0] rn;
      logic [4:0] rm;
      rng = xorshift(rng);
      rd  = pick_reg(rng >> 4);
      rn  = pick_reg(rng >> 12);
      rm  = pick_reg(rng >> 20);
      case (rng % 6)
        0: prog.push_back(enc_r(lv8_pkg::OP_ADD, rd, rn, rm));
        1: prog.push_back(enc_r(lv8_pkg::OP_SUB, rd, rn, rm));
        2: prog.push_back(enc_r(lv8_pkg::OP_AND, rd, rn, rm));
        3: prog.push_back(enc_r(lv8_pkg::OP_ORR, rd, rn, rm));
        4: prog.push_back(enc_d(lv8_pkg::OP_LDUR, rd, rn, rng[28:20]));
        default: prog.push_back(enc_d(lv8_pkg::OP_STUR, rd, rn, rng[28:20]));
      endcase
    end
    run_test("random_200", 1'b0);

    $display("Summary: %0d tests, %0d clean, %0d with errors",
             good_tests + bad_tests, good_tests, bad_tests);
    if (bad_tests == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+src
src/lv8_pkg.sv
src/lv8_fetch.sv
src/lv8_regfile.sv
src/lv8_decode.sv
src/lv8_execute.sv
src/lv8_mem_wb.sv
src/lv8_core.sv
sim/lv8_clock_gen.sv
sim/lv8_core_sva.sv
sim/lv8_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lv8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module lv8_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vlv8_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
